// ==== hdl/mlp_pkg.sv ====
package mlp_pkg;

    // Network sizes
    localparam int n_pixels  = 16;
    localparam int n_hidden  = 8;
    localparam int n_outputs = 4;

    // Counter range and steps per layer
    localparam int max_inputs   = 16;
    localparam int hidden_steps = 16;
    localparam int output_steps = 8;

    // Pixel, activation or zed
    typedef logic signed [7:0] data_t;

    // Weight or bias
    typedef logic signed [7:0] weight_t;

    // Neuron accumulator
    typedef logic signed [23:0] acc_t;

    // Input index within a layer
    typedef logic [$clog2(max_inputs)-1:0] index_t;

    // Layer select for the parameter store
    typedef enum logic {
        layer_hidden,
        layer_output
    } layer_e;

    // Sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_hidden_mac,
        st_hidden_act,
        st_output_mac,
        st_output_act
    } seq_state_e;

    // Input image
    typedef struct packed {
        data_t [n_pixels-1:0] pixel;
    } mlp_in_s;

    // Output activations
    typedef struct packed {
        data_t [n_outputs-1:0] act;
    } mlp_out_s;

    // Weights and biases of all neurons for one input index
    // Output layer only uses the low entries
    typedef struct packed {
        weight_t [n_hidden-1:0] weight;
        weight_t [n_hidden-1:0] bias;
    } weight_row_s;

endpackage

// ==== hdl/mlp_param_rom.sv ====
module mlp_param_rom
    import mlp_pkg::*;
(
    input  layer_e      layer,
    input  index_t      index,
    output weight_row_s row
);

    // Weight rule ((3n + 5i + 7l) mod 11) - 5 stays within -5..5
    function automatic weight_t rule_weight(int l, int n, int i);
        int raw;
        raw = ((3 * n + 5 * i + 7 * l) % 11) - 5;
        return weight_t'(raw);
    endfunction

    // Bias rule does not depend on layer or index
    function automatic weight_t rule_bias(int n);
        int raw;
        raw = 2 * n - 3;
        return weight_t'(raw);
    endfunction

    int layer_num;
    int index_num;

    assign layer_num = (layer == layer_output) ? 1 : 0;
    assign index_num = int'(index);

    // One row for every neuron slot
    always_comb begin
        for (int n = 0; n < n_hidden; n++) begin
            row.weight[n] = rule_weight(layer_num, n, index_num);
            row.bias[n]   = rule_bias(n);
        end
    end

endmodule

// ==== hdl/step_counter.sv ====
module step_counter
    import mlp_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   clear,
    input  logic   step,
    input  index_t last,
    output index_t index,
    output logic   at_last
);

    // Clear wins over step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            index <= '0;
        end else if (clear) begin
            index <= '0;
        end else if (step) begin
            index <= index + index_t'(1);
        end
    end

    // Terminal flag straight from the count
    assign at_last = (index == last);

endmodule

// ==== hdl/layer_sequencer.sv ====
module layer_sequencer
    import mlp_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic       at_last,
    output seq_state_e state,
    output logic       clear,
    output logic       step,
    output logic       load_hidden,
    output logic       load_output,
    output logic       mac_hidden,
    output logic       mac_output,
    output logic       capture_hidden,
    output logic       capture_result,
    output logic       busy,
    output logic       done
);

    seq_state_e next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_hidden_mac;
                end
            end
            st_hidden_mac: begin
                if (at_last) begin
                    next_state = st_hidden_act;
                end
            end
            st_hidden_act: next_state = st_output_mac;
            st_output_mac: begin
                if (at_last) begin
                    next_state = st_output_act;
                end
            end
            st_output_act: next_state = st_idle;
            default:       next_state = st_idle;
        endcase
    end

    // Start only counts in idle, so a start while busy is dropped
    assign load_hidden    = (state == st_idle) && start;
    assign load_output    = (state == st_hidden_act);
    assign capture_hidden = (state == st_hidden_act);
    assign capture_result = (state == st_output_act);

    assign mac_hidden = (state == st_hidden_mac);
    assign mac_output = (state == st_output_mac);

    // Counter restarts at the head of each layer
    assign clear = load_hidden || load_output;
    assign step  = mac_hidden || mac_output;

    assign busy = (state != st_idle);

    // One cycle after the result is written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= capture_result;
        end
    end

endmodule

// ==== hdl/mac_array.sv ====
module mac_array
    import mlp_pkg::*;
#(
    parameter int n_neurons = n_hidden
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        load,
    input  logic        enable,
    input  data_t       x,
    input  weight_row_s row,
    output acc_t        acc [n_neurons]
);

    // Shared input operand, widened once
    acc_t x_wide;

    assign x_wide = acc_t'(x);

    for (genvar n = 0; n < n_neurons; n++) begin : g_neuron
        acc_t bias_scaled;
        acc_t product;

        // Bias sits at the same scale as the products (x 128)
        assign bias_scaled = acc_t'(row.bias[n]) <<< 7;
        assign product     = x_wide * acc_t'(row.weight[n]);

        // Load takes the bias and enable adds one product
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                acc[n] <= '0;
            end else if (load) begin
                acc[n] <= bias_scaled;
            end else if (enable) begin
                acc[n] <= acc[n] + product;
            end
        end
    end

endmodule

// ==== hdl/sigmoid_layer.sv ====
module sigmoid_layer
    import mlp_pkg::*;
#(
    parameter int n_neurons = n_hidden
) (
    input  acc_t  acc [n_neurons],
    output data_t act [n_neurons]
);

    for (genvar n = 0; n < n_neurons; n++) begin : g_neuron
        acc_t  shifted;
        data_t zed;

        // Drop the fraction bits, rounding toward minus infinity
        assign shifted = acc[n] >>> 7;

        // Saturate to the 8-bit zed range
        always_comb begin
            if (shifted > acc_t'(127)) begin
                zed = 8'sd127;
            end else if (shifted < acc_t'(-128)) begin
                zed = -8'sd128;
            end else begin
                zed = data_t'(shifted[7:0]);
            end
        end

        // Hard sigmoid, result in 0..127
        assign act[n] = data_t'(8'sd64 + (zed >>> 1));
    end

endmodule

// ==== hdl/mlp.sv ====
module mlp
    import mlp_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  mlp_in_s  image,
    output logic     busy,
    output logic     done,
    output mlp_out_s result
);

    seq_state_e  state;
    logic        clear;
    logic        step;
    logic        load_hidden;
    logic        load_output;
    logic        mac_hidden;
    logic        mac_output;
    logic        capture_hidden;
    logic        capture_result;

    index_t      index;
    index_t      last;
    logic        at_last;
    layer_e      layer;
    weight_row_s row;

    mlp_in_s     image_q;
    data_t       hidden_q [n_hidden];
    data_t       hidden_x;
    data_t       output_x;

    acc_t        hidden_acc [n_hidden];
    acc_t        output_acc [n_outputs];
    data_t       hidden_act [n_hidden];
    data_t       output_act [n_outputs];

    // Output layer weights from the hidden activation phase on
    assign layer = (state == st_idle || state == st_hidden_mac) ? layer_hidden : layer_output;
    assign last  = (state == st_hidden_mac) ? index_t'(hidden_steps - 1)
                                            : index_t'(output_steps - 1);

    layer_sequencer u_sequencer (
        .clk            (clk),
        .arst_n         (arst_n),
        .start          (start),
        .at_last        (at_last),
        .state          (state),
        .clear          (clear),
        .step           (step),
        .load_hidden    (load_hidden),
        .load_output    (load_output),
        .mac_hidden     (mac_hidden),
        .mac_output     (mac_output),
        .capture_hidden (capture_hidden),
        .capture_result (capture_result),
        .busy           (busy),
        .done           (done)
    );

    step_counter u_counter (
        .clk     (clk),
        .arst_n  (arst_n),
        .clear   (clear),
        .step    (step),
        .last    (last),
        .index   (index),
        .at_last (at_last)
    );

    mlp_param_rom u_rom (
        .layer (layer),
        .index (index),
        .row   (row)
    );

    // Image is held for the whole pass
    always_ff @(posedge clk) begin
        if (load_hidden) begin
            image_q <= image;
        end
    end

    assign hidden_x = image_q.pixel[index];
    assign output_x = hidden_q[index[$clog2(n_hidden)-1:0]];

    mac_array #(.n_neurons(n_hidden)) u_hidden_mac (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load_hidden),
        .enable (mac_hidden),
        .x      (hidden_x),
        .row    (row),
        .acc    (hidden_acc)
    );

    sigmoid_layer #(.n_neurons(n_hidden)) u_hidden_sigmoid (
        .acc (hidden_acc),
        .act (hidden_act)
    );

    always_ff @(posedge clk) begin
        if (capture_hidden) begin
            hidden_q <= hidden_act;
        end
    end

    mac_array #(.n_neurons(n_outputs)) u_output_mac (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load_output),
        .enable (mac_output),
        .x      (output_x),
        .row    (row),
        .acc    (output_acc)
    );

    sigmoid_layer #(.n_neurons(n_outputs)) u_output_sigmoid (
        .acc (output_acc),
        .act (output_act)
    );

    // Result stays until the next pass completes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (capture_result) begin
            for (int n = 0; n < n_outputs; n++) begin
                result.act[n] <= output_act[n];
            end
        end
    end

endmodule

// ==== sim/mlp_model.svh ====
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// Same weight rule as the parameter store
function automatic int model_weight(int layer, int n, int i);
    return ((3 * n + 5 * i + 7 * layer) % 11) - 5;
endfunction

function automatic int model_bias(int n);
    return 2 * n - 3;
endfunction

// Shift, saturate, then hard sigmoid
function automatic int model_sigmoid(int acc);
    int zed;
    zed = acc >>> 7;
    if (zed > 127) begin
        zed = 127;
    end else if (zed < -128) begin
        zed = -128;
    end
    return 64 + (zed >>> 1);
endfunction

// Full forward pass for one image
function automatic mlp_out_s model_forward(mlp_in_s image);
    int       acc;
    int       hidden [n_hidden];
    mlp_out_s expected;
    for (int n = 0; n < n_hidden; n++) begin
        acc = model_bias(n) * 128;
        for (int i = 0; i < n_pixels; i++) begin
            acc += int'(image.pixel[i]) * model_weight(0, n, i);
        end
        hidden[n] = model_sigmoid(acc);
    end
    for (int n = 0; n < n_outputs; n++) begin
        acc = model_bias(n) * 128;
        for (int i = 0; i < n_hidden; i++) begin
            acc += hidden[i] * model_weight(1, n, i);
        end
        expected.act[n] = data_t'(model_sigmoid(acc));
    end
    return expected;
endfunction

`endif

// ==== sim/tb_mlp.sv ====
module tb_mlp
    import mlp_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "mlp_model.svh"

    localparam int latency      = 26;
    localparam int pass_timeout = 100;

    logic     clk;
    logic     arst_n;
    logic     start;
    mlp_in_s  image;
    logic     busy;
    logic     done;
    mlp_out_s result;

    int       seed;
    mlp_out_s last_result;

    mlp DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .image  (image),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual == expected) else begin
            stop_run($sformatf("mismatch at %0d ns: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    // Done is a pulse and never overlaps busy
    done_single_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else stop_run("done stayed high for more than one cycle");
    done_while_idle: assert property (@(posedge clk) disable iff (!arst_n) done |-> !busy)
        else stop_run("done was high while busy");

    function automatic mlp_in_s random_image();
        mlp_in_s img;
        for (int p = 0; p < n_pixels; p++) begin
            img.pixel[p] = data_t'($random(seed));
        end
        return img;
    endfunction

    function automatic mlp_in_s flat_image(data_t value);
        mlp_in_s img;
        for (int p = 0; p < n_pixels; p++) begin
            img.pixel[p] = value;
        end
        return img;
    endfunction

    // Idle cycles keep busy and done low and hold the result
    task automatic idle_watch(int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_value("busy", 32'd0, 32'(busy));
            check_value("done", 32'd0, 32'(done));
            check_value("result", last_result, result);
        end
    endtask

    // One pass with an optional second start injected while busy
    task automatic run_pass(mlp_in_s img, int inject_at, mlp_in_s other);
        mlp_out_s expected;
        int       edges;
        expected = model_forward(img);
        @(posedge clk);
        start <= 1'b1;
        image <= img;
        @(negedge clk);
        check_value("busy", 32'd0, 32'(busy));
        check_value("result", last_result, result);
        // E0 takes the image
        @(posedge clk);
        start <= 1'b0;
        image <= '0;
        edges = 0;
        @(negedge clk);
        while (!done) begin
            check_value("busy", 32'd1, 32'(busy));
            check_value("result", last_result, result);
            if (edges > pass_timeout) begin
                stop_run("timeout while waiting for done");
            end
            @(posedge clk);
            edges++;
            if (edges == inject_at) begin
                start <= 1'b1;
                image <= other;
            end else if (edges == inject_at + 1) begin
                start <= 1'b0;
                image <= '0;
            end
            @(negedge clk);
        end
        check_value("done latency", latency, edges);
        check_value("busy", 32'd0, 32'(busy));
        check_value("result", expected, result);
        last_result = expected;
    endtask

    initial begin
        arst_n = 1'b0;
        start  = 1'b0;
        image  = '0;
        seed   = 32'hcfc0e379;
        last_result = '0;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Quiet after reset
        idle_watch(4);

        for (int k = 0; k < 20; k++) begin
            run_pass(random_image(), -1, '0);
            idle_watch(k % 3);
        end

        // Second start mid-pass gets dropped
        run_pass(random_image(), 9, random_image());
        idle_watch(40);

        // Flat images at the pixel extremes
        run_pass(flat_image(8'sd127), -1, '0);
        idle_watch(2);
        run_pass(flat_image(-8'sd128), -1, '0);
        idle_watch(5);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+sim
hdl/mlp_pkg.sv
hdl/mlp_param_rom.sv
hdl/step_counter.sv
hdl/layer_sequencer.sv
hdl/mac_array.sv
hdl/sigmoid_layer.sv
hdl/mlp.sv
sim/tb_mlp.sv

// ==== Makefile ====
TOP = tb_mlp

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
